// File: flist.f
logic/stereo_pkg.sv
logic/stereo_loader.sv
logic/stereo_ctrl.sv
logic/scale_filter.sv
logic/disparity_calc.sv
logic/depth_store.sv
logic/stereo_top.sv
sim/tb_clock.sv
sim/sram_model.sv
sim/stereo_asserts.sv
sim/stereo_tb.sv

// File: Bender.yml
package:
  name: stereo_frontend

sources:
  - logic/stereo_pkg.sv
  - logic/stereo_loader.sv
  - logic/stereo_ctrl.sv
  - logic/scale_filter.sv
  - logic/disparity_calc.sv
  - logic/depth_store.sv
  - logic/stereo_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/sram_model.sv
      - sim/stereo_asserts.sv
      - sim/stereo_tb.sv

// File: sim/stereo_tb.sv
// Directed testbench for the stereo front end; compile with flist.f and run stereo_tb as top.
`timescale 1ns/1ns

module stereo_tb;
   import stereo_pkg::*;

   localparam int line_w  = 64;
   localparam int lines   = 48;
   localparam int frame   = line_w * lines;
   localparam int timeout = 200;                 // Cycles allowed for one query.

   logic                         tm3_clk_v0;
   logic                         rst_n;
   logic [PIX_W-1:0]             bus_word;
   load_code_e                   bus_sel;
   logic                         bus_load;
   logic [COORD_W-1:0]           xy_word;
   logic                         xy_sel;
   logic                         xy_load;
   logic                         vidin_new_data;
   logic                         nd_l [3];       // Index 0, 1 and 2 hold s1, s2 and s4.
   logic                         nd_r [3];
   logic [PIX_W-1:0]             d_l [3];
   logic [PIX_W-1:0]             d_r [3];
   logic [DEPTH_W-1:0]           depth_out;
   logic                         depth_valid;
   logic [SRAM_ADDR_W-1:0]       sram_addr;
   logic [SRAM_DATA_W-1:0]       sram_wdata;
   logic [SRAM_DATA_W-1:0]       sram_rdata;
   logic [SRAM_DATA_W/PIX_W-1:0] sram_we;
   logic [1:0]                   sram_oe;

   logic [PIX_W-1:0] ref_mem [frame];            // Expected disparity per pixel index.
   logic [PIX_W-1:0] m_thresh;
   logic [1:0]       m_gain;
   logic [PIX_W-1:0] m_left;
   logic [PIX_W-1:0] m_right;
   logic [PIX_W-1:0] win_l [4];
   logic [PIX_W-1:0] win_r [4];
   logic             exp_nd [3];
   logic [PIX_W-1:0] exp_l [3];
   logic [PIX_W-1:0] exp_r [3];
   int               wr_pos;
   int               strobes;
   string            test_name;

   tb_clock u_clock (.tm3_clk_v0);

   sram_model u_sram (
      .tm3_clk_v0, .addr(sram_addr), .wdata(sram_wdata), .we(sram_we), .oe(sram_oe),
      .rdata(sram_rdata)
   );

   stereo_top #(.line_w(line_w), .lines(lines)) u_stereo_top (
      .tm3_clk_v0, .rst_n, .bus_word, .bus_sel, .bus_load, .xy_word, .xy_sel, .xy_load,
      .vidin_new_data, .v_nd_s1_left(nd_l[0]), .v_nd_s2_left(nd_l[1]), .v_nd_s4_left(nd_l[2]),
      .v_d_s1_left(d_l[0]), .v_d_s2_left(d_l[1]), .v_d_s4_left(d_l[2]),
      .v_nd_s1_right(nd_r[0]), .v_nd_s2_right(nd_r[1]), .v_nd_s4_right(nd_r[2]),
      .v_d_s1_right(d_r[0]), .v_d_s2_right(d_r[1]), .v_d_s4_right(d_r[2]),
      .depth_out, .depth_valid, .offchip_sram_data_in(sram_rdata),
      .offchip_sram_addr(sram_addr), .offchip_sram_data_out(sram_wdata),
      .offchip_sram_we(sram_we), .offchip_sram_oe(sram_oe)
   );

   // Absolute difference, zero below threshold, shifted by gain, clipped at 255.
   function automatic logic [PIX_W-1:0] disparity_ref(input logic [PIX_W-1:0] l,
                                                      input logic [PIX_W-1:0] r);
      int d;
      d = (l > r) ? l - r : r - l;
      if (d < m_thresh) return '0;
      d = d << m_gain;
      return (d > 255) ? 8'hff : d[PIX_W-1:0];
   endfunction

   function automatic logic [PIX_W-1:0] window_avg(input logic [PIX_W-1:0] win [4],
                                                   input int last, input int n);
      int sum;
      sum = 0;
      for (int k = last - n + 1; k <= last; k++) sum += win[k];
      return PIX_W'(sum / n);
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s %s expected %0b actual %0b", test_name, what,
                            expected, actual));
   endtask

   task automatic check_pixel(input string what, input logic [PIX_W-1:0] expected,
                              input logic [PIX_W-1:0] actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s %s expected 0x%02h actual 0x%02h", test_name, what,
                            expected, actual));
   endtask

   task automatic check_depth(input string what, input logic [DEPTH_W-1:0] expected,
                              input logic [DEPTH_W-1:0] actual);
      if (actual !== expected)
         fail_run($sformatf("error: %s %s expected 0x%04h actual 0x%04h", test_name, what,
                            expected, actual));
   endtask

   // A bound assertion that fired ends the run at once.
   always @(posedge tm3_clk_v0) begin
      if (u_stereo_top.u_stereo_asserts.failures != 0)
         fail_run("an assertion on the SRAM port or the query FSM failed");
   end

   task automatic bus_write(input load_code_e sel, input logic [PIX_W-1:0] word);
      @(posedge tm3_clk_v0);
      bus_sel  <= sel;
      bus_word <= word;
      bus_load <= 1'b1;
      @(posedge tm3_clk_v0);
      bus_load <= 1'b0;
      case (sel)
         LD_THRESH:    m_thresh = word;
         LD_GAIN:      m_gain   = word[1:0];
         LD_PIX_LEFT:  m_left   = word;
         LD_PIX_RIGHT: m_right  = word;
         default: ;
      endcase
   endtask

   // Back-to-back strobes of the current pair; the model tracks phase and write position.
   task automatic strobe_pixels(input int count);
      int ph;
      for (int i = 0; i < count; i++) begin
         @(posedge tm3_clk_v0);
         vidin_new_data <= 1'b1;
         ph = strobes % 4;
         win_l[ph] = m_left;
         win_r[ph] = m_right;
         exp_nd    = '{1'b1, ph[0], ph == 3};
         exp_l[0]  = m_left;
         exp_r[0]  = m_right;
         if (ph[0]) exp_l[1] = window_avg(win_l, ph, 2);
         if (ph[0]) exp_r[1] = window_avg(win_r, ph, 2);
         if (ph == 3) exp_l[2] = window_avg(win_l, ph, 4);
         if (ph == 3) exp_r[2] = window_avg(win_r, ph, 4);
         ref_mem[wr_pos] = disparity_ref(m_left, m_right);
         wr_pos  = (wr_pos + 1) % frame;
         strobes++;
      end
      @(posedge tm3_clk_v0);
      vidin_new_data <= 1'b0;
   endtask

   task automatic send_pair(input logic [PIX_W-1:0] l, input logic [PIX_W-1:0] r);
      bus_write(LD_PIX_LEFT, l);
      bus_write(LD_PIX_RIGHT, r);
      strobe_pixels(1);
   endtask

   task automatic check_scales();
      @(posedge tm3_clk_v0);
      for (int s = 0; s < 3; s++) begin
         check_flag($sformatf("left strobe %0d", s), exp_nd[s], nd_l[s]);
         check_flag($sformatf("right strobe %0d", s), exp_nd[s], nd_r[s]);
         if (exp_nd[s]) begin
            check_pixel($sformatf("left scale %0d", s), exp_l[s], d_l[s]);
            check_pixel($sformatf("right scale %0d", s), exp_r[s], d_r[s]);
         end
      end
   endtask

   task automatic xy_write(input logic sel, input int word);
      @(posedge tm3_clk_v0);
      xy_sel  <= sel;
      xy_word <= COORD_W'(word);
      xy_load <= 1'b1;
      @(posedge tm3_clk_v0);
      xy_load <= 1'b0;
   endtask

   task automatic wait_depth(output logic [DEPTH_W-1:0] value);
      int waited;
      waited = 0;
      while (!depth_valid) begin
         if (waited == timeout) fail_run("timeout: depth_valid did not arrive after a query");
         @(posedge tm3_clk_v0);
         waited++;
      end
      value = depth_out;
   endtask

   task automatic query_check(input int pos);
      logic [DEPTH_W-1:0] got;
      xy_write(1'b0, pos % line_w);
      xy_write(1'b1, pos / line_w);
      wait_depth(got);
      check_depth($sformatf("depth at %0d", pos), DEPTH_W'(ref_mem[pos]), got);
   endtask

   task automatic test_config();
      int pos;
      test_name = "config_load";
      bus_write(LD_THRESH, 8'd12);
      bus_write(LD_GAIN, 8'h05);
      bus_write(LD_PIX_LEFT, 8'd90);
      bus_write(LD_PIX_RIGHT, 8'd30);
      for (int c = 2; c <= 5; c++) bus_write(load_code_e'(3'(c)), 8'($urandom));
      pos = wr_pos;
      strobe_pixels(1);
      check_scales();
      query_check(pos);
   endtask

   task automatic test_scales();
      test_name = "scale_outputs";
      for (int i = 0; i < 24; i++) begin
         send_pair(8'($urandom), 8'($urandom));
         check_scales();
      end
   endtask

   task automatic test_disparity();
      int pos;
      test_name = "disparity_rule";
      pos = wr_pos;
      bus_write(LD_THRESH, 8'd10);
      bus_write(LD_GAIN, 8'd0);
      send_pair(8'd50, 8'd45);                   // Below the threshold.
      send_pair(8'd40, 8'd50);                   // Exactly at the threshold.
      bus_write(LD_THRESH, 8'd4);
      bus_write(LD_GAIN, 8'd2);
      send_pair(8'd100, 8'd80);
      send_pair(8'd10, 8'd200);                  // Saturates.
      for (int k = 0; k < 4; k++) query_check((pos + k) % frame);
   endtask

   task automatic test_frame();
      test_name = "full_frame";
      bus_write(LD_THRESH, 8'd8);
      bus_write(LD_GAIN, 8'd1);
      for (int i = 0; i < frame; i++) send_pair(8'($urandom), 8'($urandom));
      for (int q = 0; q < 32; q++) query_check(int'($urandom % frame));
   endtask

   task automatic test_deferral();
      int pos;
      logic [DEPTH_W-1:0] got;
      test_name = "query_deferral";
      pos = (wr_pos + frame / 2) % frame;
      bus_write(LD_PIX_LEFT, 8'd200);
      bus_write(LD_PIX_RIGHT, 8'd17);
      fork
         strobe_pixels(40);
         begin
            repeat (4) @(posedge tm3_clk_v0);
            xy_write(1'b0, pos % line_w);
            xy_write(1'b1, pos / line_w);
            xy_write(1'b1, (pos / line_w + 1) % lines);   // Lands while the first one waits.
            wait_depth(got);
         end
      join
      check_depth("deferred depth", DEPTH_W'(ref_mem[pos]), got);
      for (int i = 0; i < 12; i++) begin
         @(posedge tm3_clk_v0);
         if (depth_valid) fail_run("a query started while busy produced a second depth_valid");
      end
   endtask

   initial begin
      void'($urandom(38));
      rst_n          = 1'b0;
      bus_word       = '0;
      bus_sel        = LD_THRESH;
      bus_load       = 1'b0;
      xy_word        = '0;
      xy_sel         = 1'b0;
      xy_load        = 1'b0;
      vidin_new_data = 1'b0;
      m_thresh       = '0;
      m_gain         = '0;
      wr_pos         = 0;
      strobes        = 0;
      repeat (10) @(posedge tm3_clk_v0);
      rst_n <= 1'b1;
      test_config();
      test_scales();
      test_disparity();
      test_frame();
      test_deferral();
      repeat (4) @(posedge tm3_clk_v0);
      if (u_stereo_top.u_stereo_asserts.failures == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1, "assertion failures were reported");
      end
   end

endmodule

// File: sim/stereo_asserts.sv
// Concurrent checks on the SRAM port and the query FSM, bound into the stereo top level.
`timescale 1ns/1ns

module stereo_asserts (
   input logic                     tm3_clk_v0,
   input logic                     rst_n,
   input stereo_pkg::query_state_e state,
   input logic                     wr_en,
   input logic                     capture,
   input logic                     depth_valid,
   input logic [7:0]               we,
   input logic [1:0]               oe
);
   import stereo_pkg::*;

   int failures = 0;

   we_onehot: assert property (@(posedge tm3_clk_v0) disable iff (!rst_n) $onehot0(we))
      else begin
         $error("SRAM write enable has more than one byte lane set");
         failures++;
      end

   we_oe_excl: assert property (@(posedge tm3_clk_v0) disable iff (!rst_n) !(|we && |oe))
      else begin
         $error("SRAM write enable and output enable are active together");
         failures++;
      end

   valid_after_capture: assert property (@(posedge tm3_clk_v0) disable iff (!rst_n)
      capture |=> depth_valid)
      else begin
         $error("depth_valid did not follow capture by one cycle");
         failures++;
      end

   write_defers_read: assert property (@(posedge tm3_clk_v0) disable iff (!rst_n)
      (state == Q_PENDING && wr_en) |=> state == Q_PENDING)
      else begin
         $error("query left the pending state during an SRAM write");
         failures++;
      end

endmodule

bind stereo_top stereo_asserts u_stereo_asserts (
   .tm3_clk_v0, .rst_n, .state(u_ctrl.state), .wr_en, .capture, .depth_valid,
   .we(offchip_sram_we), .oe(offchip_sram_oe)
);

// File: sim/sram_model.sv
// Behavioral 64-bit SRAM for the testbench with per-byte writes and a one-cycle read latency.
`timescale 1ns/1ns

module sram_model (
   input  logic                                                 tm3_clk_v0,
   input  logic [stereo_pkg::SRAM_ADDR_W-1:0]                   addr,
   input  logic [stereo_pkg::SRAM_DATA_W-1:0]                   wdata,
   input  logic [stereo_pkg::SRAM_DATA_W/stereo_pkg::PIX_W-1:0] we,
   input  logic [1:0]                                           oe,
   output logic [stereo_pkg::SRAM_DATA_W-1:0]                   rdata
);
   import stereo_pkg::*;

   logic [SRAM_DATA_W-1:0] mem [logic [SRAM_ADDR_W-1:0]];

   // Words never written read back a pattern built from every address bit.
   function automatic logic [SRAM_DATA_W-1:0] fill_word(input logic [SRAM_ADDR_W-1:0] a);
      return {a, ~a, a, 7'h35};
   endfunction

   always @(posedge tm3_clk_v0) begin
      logic [SRAM_DATA_W-1:0] word;
      word = mem.exists(addr) ? mem[addr] : fill_word(addr);
      if (|we) begin
         for (int b = 0; b < SRAM_DATA_W / PIX_W; b++) begin
            if (we[b]) word[b*PIX_W +: PIX_W] = wdata[b*PIX_W +: PIX_W];
         end
         mem[addr] = word;
      end
      if (|oe) rdata <= word;                       // Data shows up the cycle after oe.
   end

endmodule

// File: sim/tb_clock.sv
// Clock source for the stereo testbench; drives tm3_clk_v0 with a free-running 40 ns period.
`timescale 1ns/1ns

module tb_clock #(
   parameter int period = 40
) (
   output logic tm3_clk_v0
);

   initial tm3_clk_v0 = 1'b0;

   always #(period / 2) tm3_clk_v0 = ~tm3_clk_v0;   // Half period high, half low.

endmodule

// File: logic/stereo_top.sv
// Top level of the stereo front end; connects the loader, filters, disparity path and SRAM store.
`timescale 1ns/1ns

module stereo_top #(
   parameter int line_w = 64,
   parameter int lines  = 48
) (
   input  logic                                 tm3_clk_v0,
   input  logic                                 rst_n,
   input  logic [stereo_pkg::PIX_W-1:0]         bus_word,
   input  stereo_pkg::load_code_e               bus_sel,
   input  logic                                 bus_load,
   input  logic [stereo_pkg::COORD_W-1:0]       xy_word,
   input  logic                                 xy_sel,
   input  logic                                 xy_load,
   input  logic                                 vidin_new_data,
   output logic                                 v_nd_s1_left,
   output logic                                 v_nd_s2_left,
   output logic                                 v_nd_s4_left,
   output logic [stereo_pkg::PIX_W-1:0]         v_d_s1_left,
   output logic [stereo_pkg::PIX_W-1:0]         v_d_s2_left,
   output logic [stereo_pkg::PIX_W-1:0]         v_d_s4_left,
   output logic                                 v_nd_s1_right,
   output logic                                 v_nd_s2_right,
   output logic                                 v_nd_s4_right,
   output logic [stereo_pkg::PIX_W-1:0]         v_d_s1_right,
   output logic [stereo_pkg::PIX_W-1:0]         v_d_s2_right,
   output logic [stereo_pkg::PIX_W-1:0]         v_d_s4_right,
   output logic [stereo_pkg::DEPTH_W-1:0]       depth_out,
   output logic                                 depth_valid,
   input  logic [stereo_pkg::SRAM_DATA_W-1:0]   offchip_sram_data_in,
   output logic [stereo_pkg::SRAM_ADDR_W-1:0]   offchip_sram_addr,
   output logic [stereo_pkg::SRAM_DATA_W-1:0]   offchip_sram_data_out,
   output logic [stereo_pkg::SRAM_DATA_W/stereo_pkg::PIX_W-1:0] offchip_sram_we,
   output logic [1:0]                           offchip_sram_oe
);
   import stereo_pkg::*;

   logic [PIX_W-1:0]       thresh;
   logic [1:0]             gain;
   logic [PIX_W-1:0]       pix_left;
   logic [PIX_W-1:0]       pix_right;
   logic [COORD_W-1:0]     x_in;
   logic [COORD_W-1:0]     y_in;
   logic                   query_start;
   logic [PIX_W-1:0]       disp_byte;
   logic                   disp_valid;
   logic                   wr_en;
   logic                   rd_en;
   logic                   capture;
   logic [SRAM_ADDR_W+2:0] pix_index;

   stereo_loader u_loader (
      .tm3_clk_v0, .rst_n, .bus_word, .bus_sel, .bus_load, .xy_word, .xy_sel, .xy_load,
      .thresh, .gain, .pix_left, .pix_right, .x_in, .y_in, .query_start
   );

   scale_filter u_filter_left (
      .tm3_clk_v0, .rst_n, .new_data(vidin_new_data), .pix(pix_left),
      .v_nd_s1(v_nd_s1_left), .v_nd_s2(v_nd_s2_left), .v_nd_s4(v_nd_s4_left),
      .v_d_s1(v_d_s1_left), .v_d_s2(v_d_s2_left), .v_d_s4(v_d_s4_left)
   );

   scale_filter u_filter_right (
      .tm3_clk_v0, .rst_n, .new_data(vidin_new_data), .pix(pix_right),
      .v_nd_s1(v_nd_s1_right), .v_nd_s2(v_nd_s2_right), .v_nd_s4(v_nd_s4_right),
      .v_d_s1(v_d_s1_right), .v_d_s2(v_d_s2_right), .v_d_s4(v_d_s4_right)
   );

   // Both filters see the same strobe, so the left strobe qualifies the pair.
   disparity_calc u_disparity (
      .tm3_clk_v0, .rst_n, .nd_s1(v_nd_s1_left), .left_s1(v_d_s1_left),
      .right_s1(v_d_s1_right), .thresh, .gain, .disp_byte, .disp_valid
   );

   stereo_ctrl #(.line_w(line_w), .lines(lines)) u_ctrl (
      .tm3_clk_v0, .rst_n, .disp_valid, .query_start, .x_in, .y_in,
      .wr_en, .rd_en, .pix_index, .depth_valid, .capture
   );

   depth_store u_depth_store (
      .tm3_clk_v0, .rst_n, .wr_en, .rd_en, .capture, .pix_index, .disp_byte,
      .offchip_sram_data_in, .offchip_sram_addr, .offchip_sram_data_out,
      .offchip_sram_we, .offchip_sram_oe, .depth_out
   );

endmodule

// File: logic/depth_store.sv
// Drives the off-chip SRAM pins for disparity writes and depth reads and returns the read byte.
`timescale 1ns/1ns

module depth_store (
   input  logic                                 tm3_clk_v0,
   input  logic                                 rst_n,
   input  logic                                 wr_en,
   input  logic                                 rd_en,
   input  logic                                 capture,
   input  logic [stereo_pkg::SRAM_ADDR_W+2:0]   pix_index,
   input  logic [stereo_pkg::PIX_W-1:0]         disp_byte,
   input  logic [stereo_pkg::SRAM_DATA_W-1:0]   offchip_sram_data_in,
   output logic [stereo_pkg::SRAM_ADDR_W-1:0]   offchip_sram_addr,
   output logic [stereo_pkg::SRAM_DATA_W-1:0]   offchip_sram_data_out,
   output logic [stereo_pkg::SRAM_DATA_W/stereo_pkg::PIX_W-1:0] offchip_sram_we,
   output logic [1:0]                           offchip_sram_oe,
   output logic [stereo_pkg::DEPTH_W-1:0]       depth_out
);
   import stereo_pkg::*;

   localparam int LANES = SRAM_DATA_W / PIX_W;

   logic [PIX_W-1:0] byte_q;
   logic [2:0]       rd_lane;
   logic [LANES-1:0] lane_onehot;

   // The byte is delayed one cycle so it lines up with the write enable from the FSM.
   always_ff @(posedge tm3_clk_v0) begin
      byte_q <= disp_byte;
      if (rd_en) rd_lane <= pix_index[2:0];
   end

   assign lane_onehot           = LANES'(1) << pix_index[2:0];
   assign offchip_sram_addr     = pix_index[SRAM_ADDR_W+2:3];
   assign offchip_sram_data_out = {LANES{byte_q}};
   assign offchip_sram_we       = wr_en ? lane_onehot : '0;
   assign offchip_sram_oe       = rd_en ? 2'b11 : 2'b00;

   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) begin
         depth_out <= '0;
      end else if (capture) begin
         depth_out <= DEPTH_W'(offchip_sram_data_in[rd_lane * PIX_W +: PIX_W]);
      end
   end

endmodule

// File: logic/disparity_calc.sv
// Turns an unscaled left and right pixel pair into a thresholded, gained and saturated disparity.
`timescale 1ns/1ns

module disparity_calc (
   input  logic                           tm3_clk_v0,
   input  logic                           rst_n,
   input  logic                           nd_s1,
   input  logic [stereo_pkg::PIX_W-1:0]   left_s1,
   input  logic [stereo_pkg::PIX_W-1:0]   right_s1,
   input  logic [stereo_pkg::PIX_W-1:0]   thresh,
   input  logic [1:0]                     gain,
   output logic [stereo_pkg::PIX_W-1:0]   disp_byte,
   output logic                           disp_valid
);
   import stereo_pkg::*;

   logic [PIX_W-1:0] diff;
   logic [PIX_W+2:0] shifted;
   logic [PIX_W-1:0] result;

   always_comb begin
      diff    = (left_s1 > right_s1) ? left_s1 - right_s1 : right_s1 - left_s1;
      shifted = {3'b000, diff} << gain;
      if (diff < thresh)          result = '0;    // A difference equal to thresh passes.
      else if (|shifted[PIX_W+2:PIX_W]) result = '1;
      else                        result = shifted[PIX_W-1:0];
   end

   always_ff @(posedge tm3_clk_v0) begin
      if (nd_s1) disp_byte <= result;
   end

   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) disp_valid <= 1'b0;
      else        disp_valid <= nd_s1;
   end

endmodule

// File: logic/scale_filter.sv
// Produces the unscaled, pair-averaged and quad-averaged pixel streams of one camera.
`timescale 1ns/1ns

module scale_filter (
   input  logic                           tm3_clk_v0,
   input  logic                           rst_n,
   input  logic                           new_data,
   input  logic [stereo_pkg::PIX_W-1:0]   pix,
   output logic                           v_nd_s1,
   output logic                           v_nd_s2,
   output logic                           v_nd_s4,
   output logic [stereo_pkg::PIX_W-1:0]   v_d_s1,
   output logic [stereo_pkg::PIX_W-1:0]   v_d_s2,
   output logic [stereo_pkg::PIX_W-1:0]   v_d_s4
);
   import stereo_pkg::*;

   logic [1:0]       phase;
   logic [PIX_W-1:0] pix_prev;
   logic [PIX_W+1:0] acc4;
   logic [PIX_W:0]   sum2;
   logic [PIX_W+1:0] sum4;

   assign sum2 = {1'b0, pix_prev} + {1'b0, pix};
   assign sum4 = acc4 + {2'b00, pix};

   // Phase counts strobes so every line starts on a fresh window.
   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) begin
         phase   <= '0;
         v_nd_s1 <= 1'b0;
         v_nd_s2 <= 1'b0;
         v_nd_s4 <= 1'b0;
      end else begin
         v_nd_s1 <= new_data;
         v_nd_s2 <= new_data & phase[0];
         v_nd_s4 <= new_data & (phase == 2'd3);
         if (new_data) phase <= phase + 1'b1;
      end
   end

   always_ff @(posedge tm3_clk_v0) begin
      if (new_data) begin
         v_d_s1   <= pix;
         pix_prev <= pix;
         acc4     <= (phase == 2'd0) ? {2'b00, pix} : sum4;
         if (phase[0])      v_d_s2 <= sum2[PIX_W:1];
         if (phase == 2'd3) v_d_s4 <= sum4[PIX_W+1:2];
      end
   end

endmodule

// File: logic/stereo_ctrl.sv
// Tracks the write raster position and runs the depth query FSM that shares the SRAM with writes.
`timescale 1ns/1ns

module stereo_ctrl #(
   parameter int line_w = 64,
   parameter int lines  = 48
) (
   input  logic                                 tm3_clk_v0,
   input  logic                                 rst_n,
   input  logic                                 disp_valid,
   input  logic                                 query_start,
   input  logic [stereo_pkg::COORD_W-1:0]       x_in,
   input  logic [stereo_pkg::COORD_W-1:0]       y_in,
   output logic                                 wr_en,
   output logic                                 rd_en,
   output logic [stereo_pkg::SRAM_ADDR_W+2:0]   pix_index,
   output logic                                 depth_valid,
   output logic                                 capture
);
   import stereo_pkg::*;

   localparam int IDX_W = SRAM_ADDR_W + 3;
   localparam int COL_W = $clog2(line_w);
   localparam int ROW_W = $clog2(lines);

   logic [COL_W-1:0] col;
   logic [ROW_W-1:0] row;
   logic [IDX_W-1:0] wr_index;
   logic [IDX_W-1:0] rd_index;
   query_state_e     state;
   query_state_e     state_nxt;

   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) begin
         col   <= '0;
         row   <= '0;
         wr_en <= 1'b0;
      end else begin
         wr_en <= disp_valid;                   // Write lands one cycle after the byte.
         if (disp_valid) begin
            if (col == COL_W'(line_w - 1)) begin
               col <= '0;
               row <= (row == ROW_W'(lines - 1)) ? '0 : row + 1'b1;
            end else begin
               col <= col + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge tm3_clk_v0) begin
      if (disp_valid) wr_index <= IDX_W'(row * line_w + col);
      if (state == Q_IDLE && query_start) rd_index <= IDX_W'(y_in * line_w + x_in);
   end

   always_comb begin
      state_nxt = state;
      case (state)
         Q_IDLE:    if (query_start) state_nxt = Q_PENDING;
         Q_PENDING: if (!wr_en)      state_nxt = Q_READ;   // Writes always win.
         Q_READ:    state_nxt = Q_CAPTURE;
         Q_CAPTURE: state_nxt = Q_IDLE;
         default:   state_nxt = Q_IDLE;
      endcase
   end

   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) state <= Q_IDLE;
      else        state <= state_nxt;
   end

   assign rd_en       = (state == Q_PENDING) && !wr_en;
   assign capture     = (state == Q_READ);
   assign depth_valid = (state == Q_CAPTURE);
   assign pix_index   = wr_en ? wr_index : rd_index;

endmodule

// File: logic/stereo_loader.sv
// Decodes the configuration and coordinate buses into calibration, pixel and query registers.
`timescale 1ns/1ns

module stereo_loader (
   input  logic                               tm3_clk_v0,
   input  logic                               rst_n,
   input  logic [stereo_pkg::PIX_W-1:0]       bus_word,
   input  stereo_pkg::load_code_e             bus_sel,
   input  logic                               bus_load,
   input  logic [stereo_pkg::COORD_W-1:0]     xy_word,
   input  logic                               xy_sel,
   input  logic                               xy_load,
   output logic [stereo_pkg::PIX_W-1:0]       thresh,
   output logic [1:0]                         gain,
   output logic [stereo_pkg::PIX_W-1:0]       pix_left,
   output logic [stereo_pkg::PIX_W-1:0]       pix_right,
   output logic [stereo_pkg::COORD_W-1:0]     x_in,
   output logic [stereo_pkg::COORD_W-1:0]     y_in,
   output logic                               query_start
);
   import stereo_pkg::*;

   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) begin
         thresh <= '0;
         gain   <= '0;
      end else if (bus_load) begin
         case (bus_sel)
            LD_THRESH: thresh <= bus_word;
            LD_GAIN:   gain   <= bus_word[1:0];   // Shift range is 0 to 3.
            default: ;
         endcase
      end
   end

   always_ff @(posedge tm3_clk_v0) begin
      if (bus_load) begin
         case (bus_sel)
            LD_PIX_LEFT:  pix_left  <= bus_word;
            LD_PIX_RIGHT: pix_right <= bus_word;
            default: ;
         endcase
      end
      if (xy_load) begin
         if (xy_sel) y_in <= xy_word;
         else        x_in <= xy_word;
      end
   end

   // The pulse lines up with the first cycle in which y_in holds the new value.
   always_ff @(posedge tm3_clk_v0 or negedge rst_n) begin
      if (!rst_n) query_start <= 1'b0;
      else        query_start <= xy_load & xy_sel;
   end

endmodule

// File: logic/stereo_pkg.sv
// Holds the shared widths and encodings that the stereo front end and its testbench import.
package stereo_pkg;

   localparam int PIX_W       = 8;
   localparam int SRAM_DATA_W = 64;
   localparam int SRAM_ADDR_W = 19;
   localparam int COORD_W     = 16;
   localparam int DEPTH_W     = 16;

   // Codes 2 to 5 are legal on the bus but have no register here.
   typedef enum logic [2:0] {
      LD_THRESH    = 3'd0,
      LD_GAIN      = 3'd1,
      LD_PIX_LEFT  = 3'd6,
      LD_PIX_RIGHT = 3'd7
   } load_code_e;

   typedef enum logic [1:0] {
      Q_IDLE,                  // No query outstanding.
      Q_PENDING,               // Waiting for a cycle without an SRAM write.
      Q_READ,                  // Read data returns from the SRAM.
      Q_CAPTURE                // Byte is held on depth_out.
   } query_state_e;

endpackage
